/* src/prefetch_params.svh */
//////////////////////////////
// Sizing macros for the instruction prefetch controller
// Pulled in by the shared package and by any RTL that needs the depth limit
//////////////////////////////

`ifndef PREFETCH_PARAMS_SVH
`define PREFETCH_PARAMS_SVH

//////////////////////////////
// FIFO and transaction limits
//////////////////////////////

// Depth of the external fetch FIFO
// This is also the ceiling on outstanding bus transactions
`define PF_DEPTH 4

// Width of a byte address on the instruction bus
`define PF_ADDR_W 32

// Width of every counter in the design
// It must be wide enough to hold PF_DEPTH itself and not only PF_DEPTH minus one
`define PF_CNT_W 3

`endif

/* src/prefetch_pkg.sv */
//////////////////////////////
// Types shared by the prefetch controller RTL and its testbench
// Import with a wildcard import in the module header
//////////////////////////////

package prefetch_pkg;

  // Sizing macros come along with the package
  `include "prefetch_params.svh"

  //////////////////////////////
  // Data types
  //////////////////////////////

  // Byte address as seen on the instruction bus
  typedef logic [`PF_ADDR_W-1:0] addr_t;

  // Count of FIFO entries or of bus transactions in flight
  typedef logic [`PF_CNT_W-1:0] cnt_t;

  //////////////////////////////
  // Address FSM states
  //////////////////////////////

  // ST_IDLE issues sequential or fresh branch addresses
  // ST_BRANCH_WAIT replays a branch target the bus has not taken yet
  typedef enum logic {
    ST_IDLE        = 1'b0,
    ST_BRANCH_WAIT = 1'b1
  } fsm_state_e;

endpackage

/* src/fetch_addr_fsm.sv */
//////////////////////////////
// Transaction address FSM of the prefetch controller
// Picks the next fetch address and gates request valid on FIFO space
//////////////////////////////

`timescale 1ns/1ns

`include "prefetch_params.svh"

module fetch_addr_fsm import prefetch_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // Fetch stage control
  input  logic  req_i,
  input  logic  branch_i,
  input  addr_t branch_addr_i,
  // Bus adapter handshake
  input  logic  trans_ready_i,
  // Space accounting
  input  cnt_t  fifo_cnt_i,
  input  cnt_t  out_cnt_i,
  // Request towards the bus adapter
  output logic  trans_valid_o,
  output addr_t trans_addr_o,
  output logic  trans_accept_o
);

  // FSM state
  fsm_state_e state_q;
  fsm_state_e state_d;

  // Last address that was loaded into the register
  addr_t trans_addr_q;

  // Candidate addresses
  addr_t aligned_branch_addr;
  addr_t incr_addr;

  // FIFO fill level with the branch mask applied
  cnt_t fifo_cnt_masked;

  // One extra bit so the sum of two full counters cannot wrap
  logic [`PF_CNT_W:0] cnt_sum;

  //////////////////////////////
  // Request gating
  //////////////////////////////

  // A branch flushes the FIFO in the same cycle
  // So its contents cannot block the request for the branch target
  assign fifo_cnt_masked = branch_i ? '0 : fifo_cnt_i;

  // Entries already buffered plus responses still owed by the bus
  assign cnt_sum = {1'b0, fifo_cnt_masked} + {1'b0, out_cnt_i};

  // Only ask for a new word while it is certain to find a FIFO slot
  assign trans_valid_o = req_i && (cnt_sum < (`PF_CNT_W+1)'(`PF_DEPTH));

  // The one and only place where bus acceptance is decided
  assign trans_accept_o = trans_valid_o && trans_ready_i;

  //////////////////////////////
  // Address selection
  //////////////////////////////

  // Fetches are always full words
  assign aligned_branch_addr = {branch_addr_i[`PF_ADDR_W-1:2], 2'b00};

  // Next sequential word after the registered address
  assign incr_addr = {trans_addr_q[`PF_ADDR_W-1:2], 2'b00} + addr_t'(4);

  always_comb begin
    state_d      = state_q;
    trans_addr_o = trans_addr_q;

    case (state_q)
      ST_IDLE: begin
        if (branch_i) begin
          trans_addr_o = aligned_branch_addr;
          // Target not taken this cycle so keep offering it
          if (!trans_accept_o) begin
            state_d = ST_BRANCH_WAIT;
          end
        end else begin
          trans_addr_o = incr_addr;
        end
      end

      ST_BRANCH_WAIT: begin
        // A newer branch replaces the pending target
        trans_addr_o = branch_i ? aligned_branch_addr : trans_addr_q;
        if (trans_accept_o) begin
          state_d = ST_IDLE;
        end
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= ST_IDLE;
      trans_addr_q <= '0;
    end else begin
      state_q <= state_d;
      // Hold the address until the bus takes it or a branch redirects
      if (branch_i || trans_accept_o) begin
        trans_addr_q <= trans_addr_o;
      end
    end
  end

endmodule

/* src/outstanding_tracker.sv */
//////////////////////////////
// Outstanding transaction and flush bookkeeping of the prefetch controller
// Drives busy, fetch valid and the external FIFO strobes
//////////////////////////////

`timescale 1ns/1ns

module outstanding_tracker import prefetch_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  // Control flow and bus events
  input  logic branch_i,
  input  logic trans_accept_i,
  input  logic resp_valid_i,
  // Fetch stage and FIFO status
  input  logic fetch_ready_i,
  input  logic fifo_empty_i,
  // Request valid from the address FSM
  input  logic trans_valid_i,
  // Outstanding count back to the address FSM
  output cnt_t out_cnt_o,
  // Status and strobes
  output logic busy_o,
  output logic fetch_valid_o,
  output logic fifo_push_o,
  output logic fifo_pop_o,
  output logic fifo_flush_o
);

  // Transactions accepted by the bus whose response has not come back
  cnt_t out_cnt_q;
  cnt_t out_cnt_d;

  // Responses still to be thrown away after the last branch
  cnt_t flush_cnt_q;
  cnt_t flush_cnt_d;

  // FIFO holds at least one word
  logic fifo_valid;

  // Incoming responses are stale in this cycle
  logic discard;

  //////////////////////////////
  // Status and strobes
  //////////////////////////////

  assign fifo_valid = !fifo_empty_i;

  // A branch in this cycle or any flush still counting down
  assign discard = branch_i || (flush_cnt_q != '0);

  // Busy while the bus owes us data or a new request is on offer
  assign busy_o = (out_cnt_q != '0) || trans_valid_i;

  // Words come from the FIFO head or straight from the bus
  // Nothing is valid while stale data may still be arriving
  assign fetch_valid_o = (fifo_valid || resp_valid_i) && !discard;

  // A live response bypasses the FIFO only when the FIFO is empty and the fetch stage takes it
  // Otherwise it is pushed so that instruction order is kept
  assign fifo_push_o = resp_valid_i && (fifo_valid || !fetch_ready_i) && !discard;

  // The fetch stage consumes the head word
  assign fifo_pop_o = fifo_valid && fetch_ready_i;

  // Buffered words are all on the old path once a branch is taken
  assign fifo_flush_o = branch_i;

  assign out_cnt_o = out_cnt_q;

  //////////////////////////////
  // Outstanding counter
  //////////////////////////////

  // Accept and response in the same cycle cancel out
  always_comb begin
    case ({trans_accept_i, resp_valid_i})
      2'b10: begin
        out_cnt_d = out_cnt_q + cnt_t'(1);
      end
      2'b01: begin
        out_cnt_d = out_cnt_q - cnt_t'(1);
      end
      default: begin
        out_cnt_d = out_cnt_q;
      end
    endcase
  end

  //////////////////////////////
  // Flush counter
  //////////////////////////////

  always_comb begin
    flush_cnt_d = flush_cnt_q;
    if (branch_i) begin
      // Everything still in flight belongs to the old path
      flush_cnt_d = out_cnt_q;
      // A response landing with the branch is already dropped by this cycle's mask
      if (resp_valid_i && (out_cnt_q != '0)) begin
        flush_cnt_d = out_cnt_q - cnt_t'(1);
      end
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      // One stale response gone
      flush_cnt_d = flush_cnt_q - cnt_t'(1);
    end
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt_q   <= '0;
      flush_cnt_q <= '0;
    end else begin
      out_cnt_q   <= out_cnt_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

endmodule

/* src/prefetch_ctrl.sv */
//////////////////////////////
// Top level of the instruction prefetch controller
// Connects the address FSM and the outstanding tracker to the core pins
//////////////////////////////

`timescale 1ns/1ns

module prefetch_ctrl import prefetch_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,

  //////////////////////////////
  // Fetch stage
  //////////////////////////////
  input  logic  req_i,
  input  logic  branch_i,
  input  addr_t branch_addr_i,
  input  logic  fetch_ready_i,
  output logic  fetch_valid_o,
  output logic  busy_o,

  //////////////////////////////
  // Bus adapter
  //////////////////////////////
  output logic  trans_valid_o,
  output addr_t trans_addr_o,
  input  logic  trans_ready_i,
  // One pulse per accepted request and always consumed
  input  logic  resp_valid_i,

  //////////////////////////////
  // External fetch FIFO
  //////////////////////////////
  output logic  fifo_push_o,
  output logic  fifo_pop_o,
  output logic  fifo_flush_o,
  input  cnt_t  fifo_cnt_i,
  input  logic  fifo_empty_i
);

  // Bus acceptance as seen by the FSM
  logic trans_accept;

  // Responses still owed by the bus
  cnt_t out_cnt;

  // Address generation and request gating
  fetch_addr_fsm u_fetch_addr_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .trans_ready_i  (trans_ready_i),
    .fifo_cnt_i     (fifo_cnt_i),
    .out_cnt_i      (out_cnt),
    .trans_valid_o  (trans_valid_o),
    .trans_addr_o   (trans_addr_o),
    .trans_accept_o (trans_accept)
  );

  // Counting, flushing and FIFO strobes
  outstanding_tracker u_outstanding_tracker (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (branch_i),
    .trans_accept_i (trans_accept),
    .resp_valid_i   (resp_valid_i),
    .fetch_ready_i  (fetch_ready_i),
    .fifo_empty_i   (fifo_empty_i),
    .trans_valid_i  (trans_valid_o),
    .out_cnt_o      (out_cnt),
    .busy_o         (busy_o),
    .fetch_valid_o  (fetch_valid_o),
    .fifo_push_o    (fifo_push_o),
    .fifo_pop_o     (fifo_pop_o),
    .fifo_flush_o   (fifo_flush_o)
  );

endmodule

/* test/prefetch_ctrl_props.sv */
//////////////////////////////
// Concurrent assertions on the outstanding tracker
// Bound into every tracker instance from this file
//////////////////////////////

`timescale 1ns/1ns

`include "prefetch_params.svh"

module prefetch_ctrl_props import prefetch_pkg::*; (
  input logic clk,
  input logic rst_n,
  input logic branch_i,
  input logic trans_valid_i,
  input logic fetch_valid_o,
  input logic fetch_ready_i,
  input cnt_t out_cnt_o
);

  // Never more transactions in flight than FIFO slots
  out_cnt_limit: assert property (@(posedge clk) disable iff (!rst_n)
    out_cnt_o <= cnt_t'(`PF_DEPTH))
    else $error("Outstanding count went above the FIFO depth");

  // A branch comes with a request, which is offered whenever a slot is free
  branch_requests: assert property (@(posedge clk) disable iff (!rst_n)
    (branch_i && (out_cnt_o < cnt_t'(`PF_DEPTH))) |-> trans_valid_i)
    else $error("Branch cycle without a request on the bus");

  // The fetch stage must not take a word while the path is being redirected
  no_fetch_on_branch: assert property (@(posedge clk) disable iff (!rst_n)
    !(branch_i && fetch_valid_o && fetch_ready_i))
    else $error("Fetch handshake completed in a branch cycle");

endmodule

bind outstanding_tracker prefetch_ctrl_props u_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .branch_i      (branch_i),
  .trans_valid_i (trans_valid_i),
  .fetch_valid_o (fetch_valid_o),
  .fetch_ready_i (fetch_ready_i),
  .out_cnt_o     (out_cnt_o)
);

/* test/prefetch_ctrl_tb.sv */
//////////////////////////////
// Directed testbench for the prefetch controller
// Models the fetch FIFO and the bus, runs each test task and prints a verdict
//////////////////////////////

`timescale 1ns/1ns

`include "prefetch_params.svh"

module prefetch_ctrl_tb import prefetch_pkg::*; ();

  localparam int          TIMEOUT = 200;
  localparam logic [31:0] SEED    = 32'hf581812b;

  // Branch targets, deliberately unaligned
  localparam addr_t SEQ_TARGET      = 32'h0000_1003;
  localparam addr_t STALL_TARGET    = 32'h0000_2002;
  localparam addr_t THROTTLE_TARGET = 32'h0000_3001;
  localparam addr_t FLUSH_TARGET    = 32'h0000_4003;

  // DUT inputs
  logic  clk;
  logic  rst_n;
  logic  req;
  logic  branch;
  addr_t branch_addr;
  logic  fetch_ready;
  logic  trans_ready;
  logic  resp_valid;
  cnt_t  fifo_cnt;
  logic  fifo_empty;

  // DUT outputs
  logic  fetch_valid;
  logic  busy;
  logic  trans_valid;
  addr_t trans_addr;
  logic  fifo_push;
  logic  fifo_pop;
  logic  fifo_flush;

  // FIFO and bus model state, owned by the model process
  int         cycle;
  int         fifo_lvl;
  int         fifo_next;
  logic       overflow_seen;
  addr_t      acc_q[$];
  int         due_q[$];
  // One entry per response as {push, fetch valid}
  logic [1:0] resp_log[$];

  // Written by the test sequence only
  logic resp_hold;
  int   errors;

  assign fifo_cnt   = cnt_t'(fifo_lvl);
  assign fifo_empty = (fifo_lvl == 0);

  prefetch_ctrl DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .fetch_ready_i (fetch_ready),
    .fetch_valid_o (fetch_valid),
    .busy_o        (busy),
    .trans_valid_o (trans_valid),
    .trans_addr_o  (trans_addr),
    .trans_ready_i (trans_ready),
    .resp_valid_i  (resp_valid),
    .fifo_push_o   (fifo_push),
    .fifo_pop_o    (fifo_pop),
    .fifo_flush_o  (fifo_flush),
    .fifo_cnt_i    (fifo_cnt),
    .fifo_empty_i  (fifo_empty)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10;
      clk = ~clk;
    end
  end

  //////////////////////////////
  // FIFO and bus model
  //////////////////////////////

  initial begin
    void'($urandom(SEED));
    resp_valid    = 1'b0;
    fifo_lvl      = 0;
    fifo_next     = 0;
    cycle         = 0;
    overflow_seen = 1'b0;
    forever begin
      // Mid-cycle all DUT outputs have settled
      @(negedge clk);
      if (rst_n) begin
        if (trans_valid && trans_ready) begin
          acc_q.push_back(trans_addr);
          // Response due one to three cycles after acceptance
          due_q.push_back(cycle + 1 + int'($urandom % 3));
        end
        if (resp_valid) begin
          resp_log.push_back({fifo_push, fetch_valid});
        end
        if (fifo_flush) begin
          fifo_next = 0;
        end else begin
          fifo_next = fifo_lvl + int'(fifo_push) - int'(fifo_pop);
        end
        if (fifo_next > `PF_DEPTH) begin
          $display("The FIFO model overflowed at %0t ns", $time);
          overflow_seen = 1'b1;
        end
      end
      @(posedge clk);
      #2;
      cycle      = cycle + 1;
      fifo_lvl   = fifo_next;
      resp_valid = 1'b0;
      // Responses come back in order, one per cycle at most
      if (!resp_hold && (due_q.size() > 0) && (due_q[0] <= cycle)) begin
        resp_valid = 1'b1;
        void'(due_q.pop_front());
      end
    end
  end

  //////////////////////////////
  // Timing and compare helpers
  //////////////////////////////

  task automatic drive_slot;
    @(posedge clk);
    #2;
  endtask

  task automatic sample_slot;
    @(negedge clk);
    #1;
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t expected);
    if (got !== expected) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic check_cnt(input string name, input cnt_t got, input cnt_t expected);
    if (got !== expected) begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what, input int waited);
    if (waited >= TIMEOUT) begin
      $display("Timed out after %0d cycles waiting for %s", waited, what);
      errors++;
    end
  endtask

  // Sits at sample points until nothing is owed by the bus
  task automatic wait_idle(input string what);
    int n;
    n = 0;
    sample_slot();
    while ((busy || resp_valid || (due_q.size() > 0)) && (n < TIMEOUT)) begin
      sample_slot();
      n++;
    end
    report_timeout(what, n);
  endtask

  task automatic check_quiet_outputs;
    check_bit("busy_o", busy, 1'b0);
    check_bit("trans_valid_o", trans_valid, 1'b0);
    check_bit("fetch_valid_o", fetch_valid, 1'b0);
    check_bit("fifo_push_o", fifo_push, 1'b0);
    check_bit("fifo_pop_o", fifo_pop, 1'b0);
    check_bit("fifo_flush_o", fifo_flush, 1'b0);
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_reset;
    int i;
    for (i = 0; i < 4; i++) begin
      sample_slot();
      check_quiet_outputs();
    end
    drive_slot();
    rst_n = 1'b1;
    sample_slot();
    check_quiet_outputs();
  endtask

  task automatic test_sequential(input addr_t target);
    addr_t base;
    int    first;
    int    n;
    int    i;
    base  = target & ~addr_t'(3);
    first = acc_q.size();
    drive_slot();
    req         = 1'b1;
    branch      = 1'b1;
    branch_addr = target;
    sample_slot();
    check_bit("trans_valid_o", trans_valid, 1'b1);
    check_addr("trans_addr_o", trans_addr, base);
    check_bit("fifo_flush_o", fifo_flush, 1'b1);
    drive_slot();
    branch = 1'b0;
    n      = 0;
    while ((acc_q.size() - first < 8) && (n < TIMEOUT)) begin
      sample_slot();
      n++;
    end
    report_timeout("eight sequential fetches", n);
    drive_slot();
    req = 1'b0;
    for (i = 0; (i < 8) && (first + i < acc_q.size()); i++) begin
      check_addr("accepted trans_addr_o", acc_q[first + i], base + addr_t'(4 * i));
    end
    wait_idle("sequential fetch drain");
  endtask

  task automatic test_backpressure(input addr_t target, input int stall);
    addr_t base;
    int    i;
    base = target & ~addr_t'(3);
    drive_slot();
    trans_ready = 1'b0;
    req         = 1'b1;
    branch      = 1'b1;
    branch_addr = target;
    sample_slot();
    check_bit("trans_valid_o", trans_valid, 1'b1);
    check_addr("trans_addr_o", trans_addr, base);
    // The target must be replayed while the bus stalls
    for (i = 0; i < stall; i++) begin
      drive_slot();
      branch = 1'b0;
      sample_slot();
      check_bit("trans_valid_o", trans_valid, 1'b1);
      check_addr("trans_addr_o", trans_addr, base);
    end
    drive_slot();
    trans_ready = 1'b1;
    sample_slot();
    check_addr("trans_addr_o", trans_addr, base);
    drive_slot();
    sample_slot();
    check_addr("trans_addr_o", trans_addr, base + addr_t'(4));
    drive_slot();
    req = 1'b0;
    wait_idle("back-pressure drain");
  endtask

  task automatic test_throttle(input int fill);
    int first;
    int n;
    // Fill the FIFO with fill words while the fetch stage stalls
    first = acc_q.size();
    drive_slot();
    fetch_ready = 1'b0;
    trans_ready = 1'b1;
    req         = 1'b1;
    branch      = 1'b1;
    branch_addr = THROTTLE_TARGET;
    sample_slot();
    n = 0;
    while ((acc_q.size() - first < fill) && (n < TIMEOUT)) begin
      drive_slot();
      branch = 1'b0;
      sample_slot();
      n++;
    end
    report_timeout("the FIFO fill requests", n);
    drive_slot();
    req    = 1'b0;
    branch = 1'b0;
    wait_idle("the FIFO fill responses");
    check_cnt("fifo_cnt_i", fifo_cnt, cnt_t'(fill));
    // With responses held only the free slots may be requested
    resp_hold = 1'b1;
    first     = acc_q.size();
    drive_slot();
    req = 1'b1;
    repeat (3 * `PF_DEPTH) begin
      sample_slot();
    end
    check_cnt("accepted requests", cnt_t'(acc_q.size() - first), cnt_t'(`PF_DEPTH - fill));
    check_bit("trans_valid_o", trans_valid, 1'b0);
    check_bit("busy_o", busy, 1'b1);
    resp_hold = 1'b0;
    drive_slot();
    req = 1'b0;
    wait_idle("the throttled responses");
    check_cnt("fifo_cnt_i", fifo_cnt, cnt_t'(`PF_DEPTH));
    // The fetch stage now drains the full FIFO
    drive_slot();
    fetch_ready = 1'b1;
    sample_slot();
    check_bit("fifo_pop_o", fifo_pop, 1'b1);
    check_bit("fetch_valid_o", fetch_valid, 1'b1);
    n = 0;
    while (!fifo_empty && (n < TIMEOUT)) begin
      sample_slot();
      n++;
    end
    report_timeout("the FIFO to drain", n);
  endtask

  task automatic test_flush(input int n_out, input logic coincide);
    int   first;
    int   log_start;
    int   n;
    int   i;
    logic stale;
    resp_hold = 1'b1;
    first     = acc_q.size();
    drive_slot();
    fetch_ready = 1'b1;
    trans_ready = 1'b1;
    req         = 1'b1;
    sample_slot();
    n = 0;
    while ((acc_q.size() - first < n_out) && (n < TIMEOUT)) begin
      drive_slot();
      sample_slot();
      n++;
    end
    report_timeout("the requests before the branch", n);
    // Releasing now lets the oldest response land in the branch cycle
    if (coincide) begin
      resp_hold = 1'b0;
    end
    log_start = resp_log.size();
    drive_slot();
    branch      = 1'b1;
    branch_addr = FLUSH_TARGET;
    sample_slot();
    check_bit("fifo_flush_o", fifo_flush, 1'b1);
    check_bit("fetch_valid_o", fetch_valid, 1'b0);
    check_bit("fifo_push_o", fifo_push, 1'b0);
    resp_hold = 1'b0;
    drive_slot();
    branch = 1'b0;
    req    = 1'b0;
    n      = 0;
    while ((resp_log.size() - log_start < n_out + 1) && (n < TIMEOUT)) begin
      sample_slot();
      n++;
    end
    report_timeout("the responses after the branch", n);
    // Stale ones stay hidden, the target word passes straight through
    for (i = 0; log_start + i < resp_log.size(); i++) begin
      stale = (i < n_out);
      check_bit("fifo_push_o on response", resp_log[log_start + i][1], 1'b0);
      check_bit("fetch_valid_o on response", resp_log[log_start + i][0], !stale);
    end
    wait_idle("flush drain");
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    errors      = 0;
    resp_hold   = 1'b0;
    rst_n       = 1'b0;
    req         = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    fetch_ready = 1'b1;
    trans_ready = 1'b1;
    test_reset();
    test_sequential(SEQ_TARGET);
    test_backpressure(STALL_TARGET, 4);
    test_throttle(2);
    test_throttle(1);
    test_flush(3, 1'b0);
    test_flush(3, 1'b1);
    if (overflow_seen) begin
      errors++;
    end
    $display("Prefetch controller tests finished with %0d errors", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+src
src/prefetch_pkg.sv
src/fetch_addr_fsm.sv
src/outstanding_tracker.sv
src/prefetch_ctrl.sv
test/prefetch_ctrl_props.sv
test/prefetch_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the prefetch controller testbench with Verilator and run it
# The run passes only when the pass line shows up in the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module prefetch_ctrl_tb -f all.f &&
./obj_dir/Vprefetch_ctrl_tb | tee /dev/stderr | grep -qx "No errors" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
